// ==== tlb_macros.svh ====
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// number of entries, any power of two
`define TLB_NUM 16
`define TLB_IDX_W $clog2(`TLB_NUM)

// entry field widths
`define TLB_VPPN_W 19
`define TLB_ASID_W 10
`define TLB_PFN_W 20

`endif

// ==== tlb_access_pkg.sv ====
`default_nettype none

package tlb_access_pkg;

    typedef enum logic [1:0] {
        mem_fetch = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_type_e;

    typedef enum logic {
        mode_direct = 1'b0,
        mode_mapped = 1'b1
    } addr_mode_e;

    // ordered roughly by check priority
    typedef enum logic [2:0] {
        exc_none   = 3'd0,
        exc_refill = 3'd1,
        exc_pil    = 3'd2,
        exc_pis    = 3'd3,
        exc_pif    = 3'd4,
        exc_pme    = 3'd5,
        exc_ppi    = 3'd6
    } tlb_exc_e;

endpackage

`default_nettype wire

// ==== tlb_entry_pkg.sv ====
`default_nettype none

`include "tlb_macros.svh"

package tlb_entry_pkg;

    // one entry maps an even/odd page pair
    typedef struct packed {
        logic [`TLB_VPPN_W-1:0] vppn;
        logic [`TLB_ASID_W-1:0] asid;
        logic [5:0]             ps;
        logic                   e;
        logic                   g;
        logic [`TLB_PFN_W-1:0]  pfn0;
        logic [1:0]             mat0;
        logic [1:0]             plv0;
        logic                   d0;
        logic                   v0;
        logic [`TLB_PFN_W-1:0]  pfn1;
        logic [1:0]             mat1;
        logic [1:0]             plv1;
        logic                   d1;
        logic                   v1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        clr_all0       = 3'd0,
        clr_all1       = 3'd1,
        clr_g          = 3'd2,
        clr_ng         = 3'd3,
        clr_ng_asid    = 3'd4,
        clr_ng_asid_va = 3'd5,
        clr_asid_va    = 3'd6
    } invtlb_op_e;

    // large pages compare vaddr[31:22] only
    function automatic logic vppn_match(tlb_entry_t ent, logic [`TLB_VPPN_W-1:0] vppn);
        if (ent.ps == 6'd21) begin
            return ent.vppn[`TLB_VPPN_W-1:9] == vppn[`TLB_VPPN_W-1:9];
        end
        return ent.vppn == vppn;
    endfunction

endpackage

`default_nettype wire

// ==== tlb_lookup_if.sv ====
`default_nettype none

`include "tlb_macros.svh"

interface tlb_lookup_if;

    // request, valid for the cycle en is high
    logic                       en;
    logic [31:0]                vaddr;
    logic [`TLB_ASID_W-1:0]     asid;
    logic [1:0]                 plv;
    tlb_access_pkg::mem_type_e  mem_type;
    tlb_access_pkg::addr_mode_e mode;

    // registered result
    logic [31:0]                paddr;
    logic [1:0]                 mat;
    tlb_access_pkg::tlb_exc_e   exc;

    modport translate (
        input  en, vaddr, asid, plv, mem_type, mode,
        output paddr, mat, exc
    );

    modport requester (
        output en, vaddr, asid, plv, mem_type, mode,
        input  paddr, mat, exc
    );

endinterface

`default_nettype wire

// ==== tlb_memory.sv ====
`default_nettype none

`include "tlb_macros.svh"

module tlb_memory (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      we,
    input  wire logic                      fill_mode,
    input  wire logic [`TLB_IDX_W-1:0]     w_index,
    input  wire logic [`TLB_IDX_W-1:0]     f_index,
    input  wire tlb_entry_pkg::tlb_entry_t w_entry,
    input  wire logic [`TLB_IDX_W-1:0]     r_index,
    output tlb_entry_pkg::tlb_entry_t      r_entry,
    input  wire logic                      clear_en,
    input  wire tlb_entry_pkg::invtlb_op_e clear_op,
    input  wire logic [31:0]               clear_vaddr,
    input  wire logic [`TLB_ASID_W-1:0]    clear_asid,
    output tlb_entry_pkg::tlb_entry_t      entries [`TLB_NUM]
);

    logic [`TLB_IDX_W-1:0] wr_index;
    logic [`TLB_NUM-1:0]   asid_eq;
    logic [`TLB_NUM-1:0]   va_eq;
    logic [`TLB_NUM-1:0]   clear_hit;

    // refill writes go to the externally chosen slot
    assign wr_index = fill_mode ? f_index : w_index;

    assign r_entry = entries[r_index];

    // invtlb condition per entry
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_eq[i] = entries[i].asid == clear_asid;
            va_eq[i]   = tlb_entry_pkg::vppn_match(entries[i], clear_vaddr[31:13]);
            case (clear_op)
                tlb_entry_pkg::clr_all0,
                tlb_entry_pkg::clr_all1:       clear_hit[i] = 1'b1;
                tlb_entry_pkg::clr_g:          clear_hit[i] = entries[i].g;
                tlb_entry_pkg::clr_ng:         clear_hit[i] = !entries[i].g;
                tlb_entry_pkg::clr_ng_asid:    clear_hit[i] = !entries[i].g && asid_eq[i];
                tlb_entry_pkg::clr_ng_asid_va: begin
                    clear_hit[i] = !entries[i].g && asid_eq[i] && va_eq[i];
                end
                tlb_entry_pkg::clr_asid_va: begin
                    clear_hit[i] = (entries[i].g || asid_eq[i]) && va_eq[i];
                end
                default:                       clear_hit[i] = 1'b0;
            endcase
        end
    end

    // reset invalidates every entry
    // a write wins over a clear of the same slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (!rst_n) begin
                entries[i].e <= 1'b0;
            end else if (we && wr_index == i[`TLB_IDX_W-1:0]) begin
                entries[i] <= w_entry;
            end else if (clear_en && clear_hit[i]) begin
                entries[i].e <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tlb_match.sv ====
`default_nettype none

`include "tlb_macros.svh"

module tlb_match (
    input  wire tlb_entry_pkg::tlb_entry_t entries [`TLB_NUM],
    input  wire logic [`TLB_VPPN_W-1:0]    vppn,
    input  wire logic [`TLB_ASID_W-1:0]    asid,
    output logic [`TLB_NUM-1:0]            hit_vec,
    output logic                           hit,
    output logic [`TLB_IDX_W-1:0]          hit_index
);

    // valid, global or same asid, and vppn equal above the page size
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit_vec[i] = entries[i].e
                && (entries[i].g || entries[i].asid == asid)
                && tlb_entry_pkg::vppn_match(entries[i], vppn);
        end
    end

    assign hit = |hit_vec;

    // scan downwards so the lowest hit is kept
    always_comb begin
        hit_index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_index = i[`TLB_IDX_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== tlb_translate.sv ====
`default_nettype none

`include "tlb_macros.svh"

module tlb_translate (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire tlb_entry_pkg::tlb_entry_t entries [`TLB_NUM],
    tlb_lookup_if.translate                lk
);

    logic [`TLB_NUM-1:0]       hit_vec;
    logic                      hit;
    logic [`TLB_IDX_W-1:0]     hit_index;
    tlb_entry_pkg::tlb_entry_t ent;
    logic                      big;
    logic                      odd;
    logic [`TLB_PFN_W-1:0]     pfn;
    logic [1:0]                pg_mat;
    logic [1:0]                pg_plv;
    logic                      pg_d;
    logic                      pg_v;
    logic [31:0]               paddr_d;
    logic [1:0]                mat_d;
    tlb_access_pkg::tlb_exc_e  exc_d;

    tlb_match u_match (
        .entries   (entries),
        .vppn      (lk.vaddr[31:13]),
        .asid      (lk.asid),
        .hit_vec   (hit_vec),
        .hit       (hit),
        .hit_index (hit_index)
    );

    // pick the even or odd page of the hit entry
    always_comb begin
        ent    = entries[hit_index];
        big    = ent.ps == 6'd21;
        odd    = big ? lk.vaddr[21] : lk.vaddr[12];
        pfn    = odd ? ent.pfn1 : ent.pfn0;
        pg_mat = odd ? ent.mat1 : ent.mat0;
        pg_plv = odd ? ent.plv1 : ent.plv0;
        pg_d   = odd ? ent.d1 : ent.d0;
        pg_v   = odd ? ent.v1 : ent.v0;
    end

    always_comb begin
        paddr_d = big ? {pfn[`TLB_PFN_W-1:9], lk.vaddr[20:0]} : {pfn, lk.vaddr[11:0]};
        mat_d   = pg_mat;
        if (!hit) begin
            exc_d = tlb_access_pkg::exc_refill;
        end else if (!pg_v) begin
            case (lk.mem_type)
                tlb_access_pkg::mem_fetch: exc_d = tlb_access_pkg::exc_pif;
                tlb_access_pkg::mem_load:  exc_d = tlb_access_pkg::exc_pil;
                default:                   exc_d = tlb_access_pkg::exc_pis;
            endcase
        end else if (lk.plv > pg_plv) begin
            exc_d = tlb_access_pkg::exc_ppi;
        end else if (lk.mem_type == tlb_access_pkg::mem_store && !pg_d) begin
            exc_d = tlb_access_pkg::exc_pme;
        end else begin
            exc_d = tlb_access_pkg::exc_none;
        end
        // direct mode bypasses the entries, mat 1 is coherent cached
        if (lk.mode == tlb_access_pkg::mode_direct) begin
            paddr_d = lk.vaddr;
            mat_d   = 2'd1;
            exc_d   = tlb_access_pkg::exc_none;
        end
    end

    // result holds while en is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lk.paddr <= '0;
            lk.mat   <= '0;
            lk.exc   <= tlb_access_pkg::exc_none;
        end else if (lk.en) begin
            lk.paddr <= paddr_d;
            lk.mat   <= mat_d;
            lk.exc   <= exc_d;
        end
    end

endmodule

`default_nettype wire

// ==== tlb.sv ====
`default_nettype none

`include "tlb_macros.svh"

module tlb (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire tlb_access_pkg::addr_mode_e ad_mode,

    // fetch lookup
    input  wire logic                       s0_en,
    input  wire logic [31:0]                s0_vaddr,
    input  wire logic [`TLB_ASID_W-1:0]     s0_asid,
    input  wire logic [1:0]                 s0_plv,
    input  wire tlb_access_pkg::mem_type_e  s0_mem_type,
    output logic [31:0]                     s0_paddr,
    output logic [1:0]                      s0_mat,
    output tlb_access_pkg::tlb_exc_e        s0_exc,

    // data lookup
    input  wire logic                       s1_en,
    input  wire logic [31:0]                s1_vaddr,
    input  wire logic [`TLB_ASID_W-1:0]     s1_asid,
    input  wire logic [1:0]                 s1_plv,
    input  wire tlb_access_pkg::mem_type_e  s1_mem_type,
    output logic [31:0]                     s1_paddr,
    output logic [1:0]                      s1_mat,
    output tlb_access_pkg::tlb_exc_e        s1_exc,

    // write and refill
    input  wire logic                       we,
    input  wire logic                       fill_mode,
    input  wire logic [`TLB_IDX_W-1:0]      w_index,
    input  wire logic [`TLB_IDX_W-1:0]      f_index,
    input  wire logic [`TLB_VPPN_W-1:0]     w_vppn,
    input  wire logic [`TLB_ASID_W-1:0]     w_asid,
    input  wire logic [5:0]                 w_ps,
    input  wire logic                       w_e,
    input  wire logic                       w_g,
    input  wire logic [`TLB_PFN_W-1:0]      w_pfn0,
    input  wire logic [1:0]                 w_mat0,
    input  wire logic [1:0]                 w_plv0,
    input  wire logic                       w_d0,
    input  wire logic                       w_v0,
    input  wire logic [`TLB_PFN_W-1:0]      w_pfn1,
    input  wire logic [1:0]                 w_mat1,
    input  wire logic [1:0]                 w_plv1,
    input  wire logic                       w_d1,
    input  wire logic                       w_v1,

    // index read
    input  wire logic [`TLB_IDX_W-1:0]      r_index,
    output logic [`TLB_VPPN_W-1:0]          r_vppn,
    output logic [`TLB_ASID_W-1:0]          r_asid,
    output logic [5:0]                      r_ps,
    output logic                            r_g,
    output logic [`TLB_PFN_W-1:0]           r_pfn0,
    output logic [1:0]                      r_mat0,
    output logic [1:0]                      r_plv0,
    output logic                            r_d0,
    output logic                            r_v0,
    output logic [`TLB_PFN_W-1:0]           r_pfn1,
    output logic [1:0]                      r_mat1,
    output logic [1:0]                      r_plv1,
    output logic                            r_d1,
    output logic                            r_v1,

    // tlbsrch
    input  wire logic                       check_mode,
    input  wire logic [`TLB_VPPN_W-1:0]     s_vppn,
    input  wire logic [`TLB_ASID_W-1:0]     s_asid,
    output logic [`TLB_IDX_W-1:0]           s_index,
    output logic                            rs_e,

    // invtlb
    input  wire logic                       clear_en,
    input  wire tlb_entry_pkg::invtlb_op_e  clear_op,
    input  wire logic [31:0]                clear_vaddr,
    input  wire logic [`TLB_ASID_W-1:0]     clear_asid
);

    tlb_entry_pkg::tlb_entry_t entries [`TLB_NUM];
    tlb_entry_pkg::tlb_entry_t w_entry;
    tlb_entry_pkg::tlb_entry_t r_entry;
    logic [`TLB_NUM-1:0]       s_hit_vec;
    logic                      s_hit;

    tlb_lookup_if s0_lk ();
    tlb_lookup_if s1_lk ();

    assign w_entry = '{vppn: w_vppn, asid: w_asid, ps: w_ps, e: w_e, g: w_g,
                       pfn0: w_pfn0, mat0: w_mat0, plv0: w_plv0, d0: w_d0, v0: w_v0,
                       pfn1: w_pfn1, mat1: w_mat1, plv1: w_plv1, d1: w_d1, v1: w_v1};

    assign r_vppn = r_entry.vppn;
    assign r_asid = r_entry.asid;
    assign r_ps   = r_entry.ps;
    assign r_g    = r_entry.g;
    assign r_pfn0 = r_entry.pfn0;
    assign r_mat0 = r_entry.mat0;
    assign r_plv0 = r_entry.plv0;
    assign r_d0   = r_entry.d0;
    assign r_v0   = r_entry.v0;
    assign r_pfn1 = r_entry.pfn1;
    assign r_mat1 = r_entry.mat1;
    assign r_plv1 = r_entry.plv1;
    assign r_d1   = r_entry.d1;
    assign r_v1   = r_entry.v1;

    // tlbsrch hit in check mode, otherwise e of the read entry
    assign rs_e = check_mode ? s_hit : r_entry.e;

    assign s0_lk.en       = s0_en;
    assign s0_lk.vaddr    = s0_vaddr;
    assign s0_lk.asid     = s0_asid;
    assign s0_lk.plv      = s0_plv;
    assign s0_lk.mem_type = s0_mem_type;
    assign s0_lk.mode     = ad_mode;
    assign s0_paddr       = s0_lk.paddr;
    assign s0_mat         = s0_lk.mat;
    assign s0_exc         = s0_lk.exc;

    assign s1_lk.en       = s1_en;
    assign s1_lk.vaddr    = s1_vaddr;
    assign s1_lk.asid     = s1_asid;
    assign s1_lk.plv      = s1_plv;
    assign s1_lk.mem_type = s1_mem_type;
    assign s1_lk.mode     = ad_mode;
    assign s1_paddr       = s1_lk.paddr;
    assign s1_mat         = s1_lk.mat;
    assign s1_exc         = s1_lk.exc;

    tlb_memory u_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (we),
        .fill_mode   (fill_mode),
        .w_index     (w_index),
        .f_index     (f_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .r_entry     (r_entry),
        .clear_en    (clear_en),
        .clear_op    (clear_op),
        .clear_vaddr (clear_vaddr),
        .clear_asid  (clear_asid),
        .entries     (entries)
    );

    tlb_translate u_s0_translate (
        .clk     (clk),
        .rst_n   (rst_n),
        .entries (entries),
        .lk      (s0_lk.translate)
    );

    tlb_translate u_s1_translate (
        .clk     (clk),
        .rst_n   (rst_n),
        .entries (entries),
        .lk      (s1_lk.translate)
    );

    tlb_match u_search (
        .entries   (entries),
        .vppn      (s_vppn),
        .asid      (s_asid),
        .hit_vec   (s_hit_vec),
        .hit       (s_hit),
        .hit_index (s_index)
    );

endmodule

`default_nettype wire

// ==== tlb_asserts.sv ====
`default_nettype none

`include "tlb_macros.svh"

module tlb_asserts (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire tlb_access_pkg::tlb_exc_e s0_exc,
    input wire tlb_access_pkg::tlb_exc_e s1_exc,
    input wire logic                     check_mode,
    input wire logic                     rs_e,
    input wire logic [`TLB_NUM-1:0]      s_hit_vec,
    input wire logic [`TLB_NUM-1:0]      s0_hit_vec,
    input wire logic [`TLB_NUM-1:0]      s1_hit_vec
);

    // output registers come out of reset with no exception
    reset_exc: assert property (@(posedge clk) !rst_n |=>
        (s0_exc == tlb_access_pkg::exc_none && s1_exc == tlb_access_pkg::exc_none))
        else $error("lookup exc not cleared by reset");

    // at most one entry may match
    onehot_search: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_hit_vec))
        else $error("tlbsrch hit vector not one-hot");
    onehot_s0: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s0_hit_vec))
        else $error("s0 hit vector not one-hot");
    onehot_s1: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s1_hit_vec))
        else $error("s1 hit vector not one-hot");

    // no entry is valid out of reset, so the read e bit is low
    reset_e: assert property (@(posedge clk) !rst_n |=> (check_mode || !rs_e))
        else $error("read entry still valid after reset");

endmodule

bind tlb tlb_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .s0_exc     (s0_exc),
    .s1_exc     (s1_exc),
    .check_mode (check_mode),
    .rs_e       (rs_e),
    .s_hit_vec  (s_hit_vec),
    .s0_hit_vec (u_s0_translate.hit_vec),
    .s1_hit_vec (u_s1_translate.hit_vec)
);

`default_nettype wire

// ==== tb_tlb.sv ====
`default_nettype none

`include "tlb_macros.svh"

module tb_tlb;

    logic                       clk;
    logic                       rst_n;
    tlb_access_pkg::addr_mode_e ad_mode;
    logic                       s0_en;
    logic [31:0]                s0_vaddr;
    logic [`TLB_ASID_W-1:0]     s0_asid;
    logic [1:0]                 s0_plv;
    tlb_access_pkg::mem_type_e  s0_mem_type;
    logic [31:0]                s0_paddr;
    logic [1:0]                 s0_mat;
    tlb_access_pkg::tlb_exc_e   s0_exc;
    logic                       s1_en;
    logic [31:0]                s1_vaddr;
    logic [`TLB_ASID_W-1:0]     s1_asid;
    logic [1:0]                 s1_plv;
    tlb_access_pkg::mem_type_e  s1_mem_type;
    logic [31:0]                s1_paddr;
    logic [1:0]                 s1_mat;
    tlb_access_pkg::tlb_exc_e   s1_exc;
    logic                       we;
    logic                       fill_mode;
    logic [`TLB_IDX_W-1:0]      w_index;
    logic [`TLB_IDX_W-1:0]      f_index;
    logic [`TLB_VPPN_W-1:0]     w_vppn;
    logic [`TLB_ASID_W-1:0]     w_asid;
    logic [5:0]                 w_ps;
    logic                       w_e;
    logic                       w_g;
    logic [`TLB_PFN_W-1:0]      w_pfn0;
    logic [1:0]                 w_mat0;
    logic [1:0]                 w_plv0;
    logic                       w_d0;
    logic                       w_v0;
    logic [`TLB_PFN_W-1:0]      w_pfn1;
    logic [1:0]                 w_mat1;
    logic [1:0]                 w_plv1;
    logic                       w_d1;
    logic                       w_v1;
    logic [`TLB_IDX_W-1:0]      r_index;
    logic [`TLB_VPPN_W-1:0]     r_vppn;
    logic [`TLB_ASID_W-1:0]     r_asid;
    logic [5:0]                 r_ps;
    logic                       r_g;
    logic [`TLB_PFN_W-1:0]      r_pfn0;
    logic [1:0]                 r_mat0;
    logic [1:0]                 r_plv0;
    logic                       r_d0;
    logic                       r_v0;
    logic [`TLB_PFN_W-1:0]      r_pfn1;
    logic [1:0]                 r_mat1;
    logic [1:0]                 r_plv1;
    logic                       r_d1;
    logic                       r_v1;
    logic                       check_mode;
    logic [`TLB_VPPN_W-1:0]     s_vppn;
    logic [`TLB_ASID_W-1:0]     s_asid;
    logic [`TLB_IDX_W-1:0]      s_index;
    logic                       rs_e;
    logic                       clear_en;
    tlb_entry_pkg::invtlb_op_e  clear_op;
    logic [31:0]                clear_vaddr;
    logic [`TLB_ASID_W-1:0]     clear_asid;

    integer      errors;
    integer      checks;
    integer      case_count;
    integer      limit_cycles;
    integer      seed;
    integer      fd;
    integer      code;
    logic [7:0]  op;
    logic [31:0] fv [17];
    logic [8*256-1:0] line;

    tlb i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // odd fields go to the slot that is not selected, so the fill mux is exercised
    task automatic write_entry();
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fv[0], fv[1], fv[2], fv[3],
                       fv[4], fv[5], fv[6], fv[7], fv[8]);
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h", fv[9], fv[10], fv[11], fv[12],
                       fv[13], fv[14], fv[15], fv[16]);
        we        = 1'b1;
        fill_mode = fv[1][0];
        w_index   = fv[1][0] ? ~fv[0][`TLB_IDX_W-1:0] : fv[0][`TLB_IDX_W-1:0];
        f_index   = fv[1][0] ? fv[0][`TLB_IDX_W-1:0] : ~fv[0][`TLB_IDX_W-1:0];
        w_vppn    = fv[2][`TLB_VPPN_W-1:0];
        w_asid    = fv[3][`TLB_ASID_W-1:0];
        w_ps      = fv[4][5:0];
        w_e       = fv[5][0];
        w_g       = fv[6][0];
        w_pfn0    = fv[7][`TLB_PFN_W-1:0];
        w_mat0    = fv[8][1:0];
        w_plv0    = fv[9][1:0];
        w_d0      = fv[10][0];
        w_v0      = fv[11][0];
        w_pfn1    = fv[12][`TLB_PFN_W-1:0];
        w_mat1    = fv[13][1:0];
        w_plv1    = fv[14][1:0];
        w_d1      = fv[15][0];
        w_v1      = fv[16][0];
        @(posedge clk);
        #2 we = 1'b0;
    endtask

    task automatic read_entry();
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h", fv[0], fv[1], fv[2], fv[3],
                       fv[4], fv[5], fv[6], fv[7]);
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h", fv[8], fv[9], fv[10], fv[11],
                       fv[12], fv[13], fv[14], fv[15]);
        r_index    = fv[0][`TLB_IDX_W-1:0];
        check_mode = 1'b0;
        #1;
        check_val("r_vppn", r_vppn, fv[1]);
        check_val("r_asid", r_asid, fv[2]);
        check_val("r_ps", r_ps, fv[3]);
        check_val("rs_e", rs_e, fv[4]);
        check_val("r_g", r_g, fv[5]);
        check_val("r_pfn0", r_pfn0, fv[6]);
        check_val("r_mat0", r_mat0, fv[7]);
        check_val("r_plv0", r_plv0, fv[8]);
        check_val("r_d0", r_d0, fv[9]);
        check_val("r_v0", r_v0, fv[10]);
        check_val("r_pfn1", r_pfn1, fv[11]);
        check_val("r_mat1", r_mat1, fv[12]);
        check_val("r_plv1", r_plv1, fv[13]);
        check_val("r_d1", r_d1, fv[14]);
        check_val("r_v1", r_v1, fv[15]);
    endtask

    task automatic drive_port(input logic port, input logic en, input logic [31:0] va,
                              input logic [31:0] asid, input logic [1:0] plv,
                              input logic [1:0] typ);
        if (port) begin
            s1_en       = en;
            s1_vaddr    = va;
            s1_asid     = asid[`TLB_ASID_W-1:0];
            s1_plv      = plv;
            s1_mem_type = tlb_access_pkg::mem_type_e'(typ);
        end else begin
            s0_en       = en;
            s0_vaddr    = va;
            s0_asid     = asid[`TLB_ASID_W-1:0];
            s0_plv      = plv;
            s0_mem_type = tlb_access_pkg::mem_type_e'(typ);
        end
    endtask

    // paddr and mat only mean something without an exception
    task automatic check_port(input logic port, input logic [31:0] paddr,
                              input logic [31:0] mat, input logic [31:0] exc);
        if (port) begin
            check_val("s1_exc", s1_exc, exc);
            if (exc == 0) begin
                check_val("s1_paddr", s1_paddr, paddr);
                check_val("s1_mat", s1_mat, mat);
            end
        end else begin
            check_val("s0_exc", s0_exc, exc);
            if (exc == 0) begin
                check_val("s0_paddr", s0_paddr, paddr);
                check_val("s0_mat", s0_mat, mat);
            end
        end
    endtask

    task automatic lookup();
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fv[0], fv[1], fv[2], fv[3],
                       fv[4], fv[5], fv[6], fv[7], fv[8]);
        ad_mode = tlb_access_pkg::addr_mode_e'(fv[1][0]);
        drive_port(fv[0][0], 1'b1, fv[2], fv[3], fv[4][1:0], fv[5][1:0]);
        @(posedge clk);
        #2;
        drive_port(fv[0][0], 1'b0, 32'h0, 32'h0, 2'd0, 2'd0);
        check_port(fv[0][0], fv[6], fv[7], fv[8]);
    endtask

    task automatic search();
        code = $fscanf(fd, "%h %h %h %h", fv[0], fv[1], fv[2], fv[3]);
        s_vppn     = fv[0][`TLB_VPPN_W-1:0];
        s_asid     = fv[1][`TLB_ASID_W-1:0];
        check_mode = 1'b1;
        #1;
        check_val("rs_e", rs_e, fv[2]);
        if (fv[2][0]) begin
            check_val("s_index", s_index, fv[3]);
        end
        check_mode = 1'b0;
    endtask

    task automatic invalidate();
        code = $fscanf(fd, "%h %h %h", fv[0], fv[1], fv[2]);
        clear_en    = 1'b1;
        clear_op    = tlb_entry_pkg::invtlb_op_e'(fv[0][2:0]);
        clear_asid  = fv[1][`TLB_ASID_W-1:0];
        clear_vaddr = fv[2];
        @(posedge clk);
        #2 clear_en = 1'b0;
    endtask

    // the table is empty after the case file, so load one global entry for clr_all0
    task automatic clear_all0_check();
        we        = 1'b1;
        fill_mode = 1'b0;
        w_index   = '0;
        w_vppn    = 19'h00070;
        w_asid    = 10'h005;
        w_ps      = 6'd12;
        w_e       = 1'b1;
        w_g       = 1'b1;
        w_pfn0    = 20'h12345;
        w_mat0    = 2'd1;
        w_plv0    = 2'd3;
        w_d0      = 1'b1;
        w_v0      = 1'b1;
        @(posedge clk);
        #2 we = 1'b0;
        ad_mode = tlb_access_pkg::mode_mapped;
        drive_port(1'b0, 1'b1, 32'h000e0004, 32'h0, 2'd0, 2'd0);
        @(posedge clk);
        #2;
        drive_port(1'b0, 1'b0, 32'h0, 32'h0, 2'd0, 2'd0);
        check_port(1'b0, 32'h12345004, 32'd1, 32'd0);
        clear_en = 1'b1;
        clear_op = tlb_entry_pkg::clr_all0;
        @(posedge clk);
        #2 clear_en = 1'b0;
        drive_port(1'b0, 1'b1, 32'h000e0004, 32'h0, 2'd0, 2'd0);
        @(posedge clk);
        #2;
        drive_port(1'b0, 1'b0, 32'h0, 32'h0, 2'd0, 2'd0);
        check_port(1'b0, 32'h0, 32'd0, 32'd1);
    endtask

    // table is empty here, so mapped lookups must refill
    task automatic random_lookups();
        logic [31:0] va0;
        logic [31:0] va1;
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic [31:0] hold_paddr;
        logic [31:0] hold_exc;
        repeat (20) begin
            va0     = $random(seed);
            va1     = $random(seed);
            ad_mode = tlb_access_pkg::addr_mode_e'($random(seed) & 1);
            drive_port(1'b0, 1'b1, va0, $random(seed), 2'd0, 2'd0);
            drive_port(1'b1, 1'b1, va1, $random(seed), 2'd0, 2'd1);
            @(posedge clk);
            #2;
            exp0 = ad_mode == tlb_access_pkg::mode_direct ? 32'd0 : 32'd1;
            exp1 = exp0;
            check_port(1'b0, va0, 32'd1, exp0);
            check_port(1'b1, va1, 32'd1, exp1);
        end
        hold_paddr = s0_paddr;
        hold_exc   = s1_exc;
        drive_port(1'b0, 1'b0, ~va0, 32'h0, 2'd0, 2'd0);
        drive_port(1'b1, 1'b0, ~va1, 32'h0, 2'd0, 2'd0);
        ad_mode = tlb_access_pkg::mode_direct;
        @(posedge clk);
        #2;
        check_val("s0_paddr", s0_paddr, hold_paddr);
        check_val("s1_exc", s1_exc, hold_exc);
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish in %0d cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        case_count = 0;
        seed = 32'h45fe;
        rst_n = 1'b0;
        ad_mode = tlb_access_pkg::mode_mapped;
        drive_port(1'b0, 1'b0, 32'h0, 32'h0, 2'd0, 2'd0);
        drive_port(1'b1, 1'b0, 32'h0, 32'h0, 2'd0, 2'd0);
        {we, fill_mode, w_index, f_index, w_vppn, w_asid, w_ps, w_e, w_g} = '0;
        {w_pfn0, w_mat0, w_plv0, w_d0, w_v0, w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = '0;
        r_index = '0;
        check_mode = 1'b0;
        s_vppn = '0;
        s_asid = '0;
        clear_en = 1'b0;
        clear_op = tlb_entry_pkg::clr_all0;
        clear_vaddr = '0;
        clear_asid = '0;

        fd = $fopen("tlb_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tlb_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) case_count++;
            end
            $fclose(fd);
        end
        limit_cycles = (case_count + 40) * 20;

        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;

        fd = $fopen("tlb_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) break;
                case (op)
                    "#": code = $fgets(line, fd);
                    "W": write_entry();
                    "R": read_entry();
                    "L": lookup();
                    "S": search();
                    "I": invalidate();
                    default: begin
                        errors++;
                        $display("unknown operation '%c' in case file", op);
                        code = $fgets(line, fd);
                    end
                endcase
            end
            $fclose(fd);
        end

        clear_all0_check();
        random_lookups();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
tlb_access_pkg.sv
tlb_entry_pkg.sv
tlb_lookup_if.sv
tlb_memory.sv
tlb_match.sv
tlb_translate.sv
tlb.sv
tlb_asserts.sv
tb_tlb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wall -Wno-fatal -f filelist.f \
		--top-module tb_tlb -Mdir obj_dir -o sim_tlb

run: compile
	./obj_dir/sim_tlb 2>&1 | tee run.log
	@grep -q "Test passed" run.log

clean:
	rm -rf obj_dir run.log

// ==== tlb_cases.txt ====
# W idx fill vppn asid ps e g pfn0 mat0 plv0 d0 v0 pfn1 mat1 plv1 d1 v1; R idx, then same fields
# L port mode vaddr asid plv type paddr mat exc; S vppn asid hit index; I op asid vaddr
W 0 0 00010 001 0c 1 0 11111 1 3 1 1 22222 0 3 0 1
W 5 1 40200 3ff 15 1 1 12200 1 0 1 1 34600 2 0 1 1
W 2 0 00030 002 0c 1 0 77777 1 0 1 0 33333 1 0 1 1
W 3 0 00040 002 0c 1 0 44444 1 3 1 1 55555 1 3 1 1
R 0 00010 001 0c 1 0 11111 1 3 1 1 22222 0 3 0 1
R 5 40200 3ff 15 1 1 12200 1 0 1 1 34600 2 0 1 1
R 2 00030 002 0c 1 0 77777 1 0 1 0 33333 1 0 1 1
L 0 1 00020abc 001 0 1 11111abc 1 0
L 1 1 00021def 001 0 1 22222def 0 0
L 1 1 00021def 001 0 2 0 0 5
L 0 1 00020abc 002 0 0 0 0 1
L 1 1 80412345 155 0 1 12212345 1 0
L 0 1 80612345 0aa 0 0 34612345 2 0
L 1 1 80612345 155 3 1 0 0 6
L 0 1 00060100 002 0 0 0 0 4
L 1 1 00060100 002 0 1 0 0 2
L 1 1 00060100 002 0 2 0 0 3
L 1 1 00060100 002 3 1 0 0 2
L 1 1 00061100 002 0 2 33333100 1 0
L 0 0 12345678 000 0 0 12345678 1 0
S 00010 001 1 0
S 40209 007 1 5
S 00010 002 0 0
I 5 002 00060000
S 00030 002 0 0
L 1 1 00061100 002 0 1 0 0 1
L 0 1 00080010 002 0 0 44444010 1 0
I 4 001 00000000
L 0 1 00020abc 001 0 1 0 0 1
L 1 1 00081020 002 0 1 55555020 1 0
I 2 000 00000000
L 0 1 80412345 155 0 1 0 0 1
W 6 0 00050 000 0c 1 1 66666 1 3 1 1 66667 1 3 1 1
I 3 000 00000000
L 1 1 00080010 002 0 1 0 0 1
L 0 1 000a0123 3a1 0 1 66666123 1 0
I 6 000 000a0000
L 0 1 000a0123 3a1 0 1 0 0 1
W 7 1 00070 005 0c 1 0 12345 1 3 1 1 12346 1 3 1 1
L 1 1 000e0004 005 0 1 12345004 1 0
I 1 000 00000000
L 1 1 000e0004 005 0 1 0 0 1
I 0 000 00000000
